// ==== hdl/rackbus_pkg.sv ====
`default_nettype none

package rackbus_pkg;

    // widths of the command words that travel over the rack bus
    localparam int unsigned runcmd_bits = 2;
    localparam int unsigned trig_bits = 15;

    // firmware bytes leave the register block one at a time
    localparam int unsigned fw_byte_bits = 8;

    // each stream carries its data and valid together, ready comes back separately
    typedef struct packed {
        logic [runcmd_bits-1:0] tdata;
        logic                   tvalid;
    } runcmd_stream_t;

    typedef struct packed {
        logic [trig_bits-1:0] tdata;
        logic                 tvalid;
    } trig_stream_t;

    // bytes of a firmware word, least significant byte first
    typedef struct packed {
        logic [fw_byte_bits-1:0] tdata;
        logic                    tvalid;
    } fw_stream_t;

endpackage

`default_nettype wire

// ==== hdl/surf_regs_pkg.sv ====
`default_nettype none

package surf_regs_pkg;

    // the target decodes a 10 bit word space, only the low nibble selects a register
    localparam int unsigned wb_adr_bits = 10;

    localparam logic [3:0] control_addr = 4'h0;
    localparam logic [3:0] fwupdate_addr = 4'h4;
    localparam logic [3:0] runcmd_addr = 4'h8;
    localparam logic [3:0] trig_addr = 4'hC;

    // depth of the firmware FIFO in 32 bit words
    localparam int unsigned fw_fifo_words = 16;

    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [wb_adr_bits-1:0] adr;
        logic [3:0]             sel;
        logic [31:0]            dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic        err;
        logic        rty;
        logic [31:0] dat;
    } wb_rsp_t;

    // layout of the control register as seen by a write
    typedef struct packed {
        logic        rxclk_disable;
        logic [21:0] reserved_hi;
        logic        fw_mark_req;
        logic [6:0]  reserved_lo;
        logic        fifo_reset;
    } ctrl_write_t;

    // layout returned by any read
    typedef struct packed {
        logic        rxclk_disable;
        logic [21:0] reserved_hi;
        logic        fw_mark_pending;
        logic [3:0]  reserved_lo;
        logic        trig_idle;
        logic        runcmd_idle;
        logic        fifo_empty;
        logic        fifo_reset;
    } status_read_t;

    // the control address decodes the same word two ways
    typedef union packed {
        ctrl_write_t  wr;
        status_read_t st;
    } ctrl_word_u;

endpackage

`default_nettype wire

// ==== hdl/flag_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module flag_sync (
    input  logic in_clk_i,
    input  logic in_flag_i,
    input  logic out_clk_i,
    output logic out_flag_o
);

    // source side level that flips once per input pulse
    logic       toggle_q = 1'b0;

    // destination copies of the toggle, the first one may go metastable
    logic [2:0] sync_q = 3'b000;

    always_ff @(posedge in_clk_i) begin
        if (in_flag_i) begin
            toggle_q <= ~toggle_q;
        end
    end

    always_ff @(posedge out_clk_i) begin
        sync_q <= {sync_q[1:0], toggle_q};
    end

    // any change of the settled toggle is one event on this side
    assign out_flag_o = sync_q[2] ^ sync_q[1];

endmodule

`default_nettype wire

// ==== hdl/fwupdate_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module fwupdate_fifo (
    input  logic                    wr_clk_i,
    input  logic                    rd_clk_i,
    input  logic                    flush_i,
    input  logic                    wr_en_i,
    input  logic [31:0]             wr_data_i,
    output logic                    empty_o,
    output rackbus_pkg::fw_stream_t fw_o,
    input  logic                    fw_ready_i
);

    // one extra bit above the word address tells full from empty
    typedef logic [$clog2(surf_regs_pkg::fw_fifo_words):0] ptr_t;

    logic [31:0] mem_q [surf_regs_pkg::fw_fifo_words];

    // write domain
    ptr_t wr_bin_q = '0;
    ptr_t wr_gray_q = '0;
    ptr_t wr_bin_next;
    ptr_t rd_gray_meta_q = '0;
    ptr_t rd_gray_sync_q = '0;
    logic full;

    // read domain
    ptr_t rd_bin_q = '0;
    ptr_t rd_gray_q = '0;
    ptr_t rd_bin_next;
    ptr_t wr_gray_meta_q = '0;
    ptr_t wr_gray_sync_q = '0;
    logic [1:0] flush_rd_q = 2'b00;
    logic [1:0] byte_idx_q = 2'b00;
    logic [31:0] head_word;
    logic accept;

    assign wr_bin_next = wr_bin_q + 1'b1;
    assign rd_bin_next = rd_bin_q + 1'b1;

    // full when the write pointer is one lap ahead of the synchronised read pointer
    assign full = (wr_gray_q == {~rd_gray_sync_q[$bits(ptr_t)-1 -: 2],
                                 rd_gray_sync_q[$bits(ptr_t)-3:0]});

    always_ff @(posedge wr_clk_i) begin
        if (flush_i) begin
            wr_bin_q <= '0;
            wr_gray_q <= '0;
        end else if (wr_en_i) begin
            wr_bin_q <= wr_bin_next;
            wr_gray_q <= wr_bin_next ^ (wr_bin_next >> 1);
        end
        rd_gray_meta_q <= rd_gray_q;
        rd_gray_sync_q <= rd_gray_meta_q;
    end

    always_ff @(posedge wr_clk_i) begin
        if (wr_en_i && !flush_i) begin
            mem_q[wr_bin_q[$bits(ptr_t)-2:0]] <= wr_data_i;
        end
    end

    // the flush reaches the read side ahead of the cleared write pointer,
    // so the stream is held off until both pointers agree again
    assign empty_o = flush_rd_q[1] || (rd_gray_q == wr_gray_sync_q);
    assign accept = fw_o.tvalid && fw_ready_i;
    assign head_word = mem_q[rd_bin_q[$bits(ptr_t)-2:0]];

    always_ff @(posedge rd_clk_i) begin
        flush_rd_q <= {flush_rd_q[0], flush_i};
        wr_gray_meta_q <= wr_gray_q;
        wr_gray_sync_q <= wr_gray_meta_q;
        if (flush_rd_q[1]) begin
            rd_bin_q <= '0;
            rd_gray_q <= '0;
            byte_idx_q <= 2'b00;
        end else if (accept) begin
            // the word leaves once its last byte is taken
            if (byte_idx_q == 2'b11) begin
                rd_bin_q <= rd_bin_next;
                rd_gray_q <= rd_bin_next ^ (rd_bin_next >> 1);
            end
            byte_idx_q <= byte_idx_q + 2'b01;
        end
    end

    always_comb begin
        fw_o.tvalid = !empty_o;
        fw_o.tdata = head_word[8*byte_idx_q +: 8];
    end

    // software is trusted to stay within the depth, this catches when it does not
    full_write_a: assert property (@(posedge wr_clk_i) disable iff (flush_i)
        !(wr_en_i && full))
        else $error("firmware FIFO written while full");

endmodule

`default_nettype wire

// ==== hdl/surfturf_register_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module surfturf_register_core (
    input  logic                        wb_clk_i,
    input  logic                        sysclk_i,
    input  logic                        reset_i,
    input  surf_regs_pkg::wb_req_t      wb_req_i,
    output surf_regs_pkg::wb_rsp_t      wb_rsp_o,
    output logic                        disable_rxclk_o,
    output rackbus_pkg::fw_stream_t     fw_o,
    input  logic                        fw_ready_i,
    output logic                        fw_mark_o,
    input  logic                        fw_marked_i,
    output rackbus_pkg::runcmd_stream_t runcmd_o,
    input  logic                        runcmd_ready_i,
    output rackbus_pkg::trig_stream_t   trig_o,
    input  logic                        trig_ready_i
);

    // bus domain
    logic [1:0] reset_wb_q = 2'b11;
    logic reset_wb;
    logic ack_q;
    logic wb_ack;
    logic acked_write;
    logic [3:0] reg_addr;
    surf_regs_pkg::ctrl_word_u wr_word;
    surf_regs_pkg::ctrl_word_u status_word;
    logic ctrl_wr;
    logic fw_wr;
    logic runcmd_wr;
    logic trig_wr;
    logic mark_req_wb;
    logic fifo_reset_q;
    logic fifo_flush;
    logic rxclk_disable_q;
    logic fw_mark_wb_q;
    logic fw_pending_wr_q;
    logic fw_marked_wb;
    logic fw_drained_wb;
    logic [rackbus_pkg::runcmd_bits-1:0] runcmd_hold_q;
    logic [rackbus_pkg::trig_bits-1:0] trig_hold_q;
    logic [1:0] runcmd_valid_wb_q;
    logic [1:0] trig_valid_wb_q;
    logic [1:0] fw_empty_wb_q;

    // sysclk domain
    logic runcmd_strobe_sys;
    logic trig_strobe_sys;
    logic mark_req_sys;
    logic runcmd_valid_q;
    logic trig_valid_q;
    logic [rackbus_pkg::runcmd_bits-1:0] runcmd_data_q;
    logic [rackbus_pkg::trig_bits-1:0] trig_data_q;
    logic fw_mark_sys_q;
    logic fw_marked_sys;
    logic fifo_empty_sys;
    logic fw_empty_sys_q;
    logic fw_drained_sys;
    logic [1:0] rxclk_disable_sys_q;

    assign reset_wb = reset_wb_q[1];

    // ack follows stb by one cycle and drops at once with cyc
    assign wb_ack = ack_q && wb_req_i.cyc;
    assign acked_write = wb_req_i.cyc && wb_req_i.stb && wb_req_i.we && wb_ack;
    assign reg_addr = wb_req_i.adr[3:0];
    assign wr_word = wb_req_i.dat;

    assign ctrl_wr = acked_write && (reg_addr == surf_regs_pkg::control_addr);
    assign fw_wr = acked_write && (reg_addr == surf_regs_pkg::fwupdate_addr);
    assign runcmd_wr = acked_write && (reg_addr == surf_regs_pkg::runcmd_addr) &&
                       wb_req_i.sel[0];
    assign trig_wr = acked_write && (reg_addr == surf_regs_pkg::trig_addr) &&
                     (wb_req_i.sel[1:0] == 2'b11);
    assign mark_req_wb = ctrl_wr && wr_word.wr.fw_mark_req && wb_req_i.sel[1];

    // the FIFO is also emptied while the bus side is held in reset
    assign fifo_flush = fifo_reset_q || reset_wb;

    always_ff @(posedge wb_clk_i) begin
        reset_wb_q <= {reset_wb_q[0], reset_i};
        if (reset_wb) begin
            ack_q <= 1'b0;
            fifo_reset_q <= 1'b0;
            rxclk_disable_q <= 1'b1;
            fw_mark_wb_q <= 1'b0;
            fw_pending_wr_q <= 1'b0;
            runcmd_valid_wb_q <= 2'b00;
            trig_valid_wb_q <= 2'b00;
            fw_empty_wb_q <= 2'b11;
        end else begin
            ack_q <= wb_req_i.cyc && wb_req_i.stb && !wb_ack;
            if (ctrl_wr && wb_req_i.sel[0]) begin
                fifo_reset_q <= wr_word.wr.fifo_reset;
            end
            if (ctrl_wr && wb_req_i.sel[3]) begin
                rxclk_disable_q <= wr_word.wr.rxclk_disable;
            end
            // writing the mark again resends the request if the first was lost
            if (mark_req_wb) begin
                fw_mark_wb_q <= 1'b1;
            end else if (fw_marked_wb) begin
                fw_mark_wb_q <= 1'b0;
            end
            // hides a stale empty level until the words just written have drained
            if (fifo_reset_q) begin
                fw_pending_wr_q <= 1'b0;
            end else if (fw_wr) begin
                fw_pending_wr_q <= 1'b1;
            end else if (fw_drained_wb) begin
                fw_pending_wr_q <= 1'b0;
            end
            runcmd_valid_wb_q <= {runcmd_valid_wb_q[0], runcmd_valid_q};
            trig_valid_wb_q <= {trig_valid_wb_q[0], trig_valid_q};
            fw_empty_wb_q <= {fw_empty_wb_q[0], fw_empty_sys_q};
        end
    end

    // payload is captured at the write and only sampled in sysclk after the strobe lands
    always_ff @(posedge wb_clk_i) begin
        if (runcmd_wr) begin
            runcmd_hold_q <= wb_req_i.dat[rackbus_pkg::runcmd_bits-1:0];
        end
        if (trig_wr) begin
            trig_hold_q <= wb_req_i.dat[rackbus_pkg::trig_bits-1:0];
        end
    end

    always_comb begin
        status_word = '0;
        status_word.st.rxclk_disable = rxclk_disable_q;
        status_word.st.fw_mark_pending = fw_mark_wb_q;
        status_word.st.trig_idle = !trig_valid_wb_q[1];
        status_word.st.runcmd_idle = !runcmd_valid_wb_q[1];
        status_word.st.fifo_empty = fw_empty_wb_q[1] && !fw_pending_wr_q;
        status_word.st.fifo_reset = fifo_reset_q;
    end

    always_comb begin
        wb_rsp_o.ack = wb_ack;
        wb_rsp_o.err = 1'b0;
        wb_rsp_o.rty = 1'b0;
        wb_rsp_o.dat = status_word;
    end

    flag_sync runcmd_sync_inst (
        .in_clk_i   (wb_clk_i),
        .in_flag_i  (runcmd_wr),
        .out_clk_i  (sysclk_i),
        .out_flag_o (runcmd_strobe_sys)
    );

    flag_sync trig_sync_inst (
        .in_clk_i   (wb_clk_i),
        .in_flag_i  (trig_wr),
        .out_clk_i  (sysclk_i),
        .out_flag_o (trig_strobe_sys)
    );

    flag_sync mark_sync_inst (
        .in_clk_i   (wb_clk_i),
        .in_flag_i  (mark_req_wb),
        .out_clk_i  (sysclk_i),
        .out_flag_o (mark_req_sys)
    );

    flag_sync marked_sync_inst (
        .in_clk_i   (sysclk_i),
        .in_flag_i  (fw_marked_sys),
        .out_clk_i  (wb_clk_i),
        .out_flag_o (fw_marked_wb)
    );

    flag_sync drained_sync_inst (
        .in_clk_i   (sysclk_i),
        .in_flag_i  (fw_drained_sys),
        .out_clk_i  (wb_clk_i),
        .out_flag_o (fw_drained_wb)
    );

    fwupdate_fifo fwupdate_fifo_inst (
        .wr_clk_i   (wb_clk_i),
        .rd_clk_i   (sysclk_i),
        .flush_i    (fifo_flush),
        .wr_en_i    (fw_wr),
        .wr_data_i  (wb_req_i.dat),
        .empty_o    (fifo_empty_sys),
        .fw_o       (fw_o),
        .fw_ready_i (fw_ready_i)
    );

    // the acknowledge is only sent while the loader still sees the mark
    assign fw_marked_sys = fw_mark_sys_q && fw_marked_i;
    assign fw_drained_sys = fifo_empty_sys && !fw_empty_sys_q;

    always_ff @(posedge sysclk_i) begin
        if (reset_i) begin
            runcmd_valid_q <= 1'b0;
            trig_valid_q <= 1'b0;
            fw_mark_sys_q <= 1'b0;
            fw_empty_sys_q <= 1'b1;
            rxclk_disable_sys_q <= 2'b11;
        end else begin
            if (runcmd_strobe_sys) begin
                runcmd_valid_q <= 1'b1;
            end else if (runcmd_valid_q && runcmd_ready_i) begin
                runcmd_valid_q <= 1'b0;
            end
            if (trig_strobe_sys) begin
                trig_valid_q <= 1'b1;
            end else if (trig_valid_q && trig_ready_i) begin
                trig_valid_q <= 1'b0;
            end
            if (mark_req_sys) begin
                fw_mark_sys_q <= 1'b1;
            end else if (fw_marked_i) begin
                fw_mark_sys_q <= 1'b0;
            end
            fw_empty_sys_q <= fifo_empty_sys;
            rxclk_disable_sys_q <= {rxclk_disable_sys_q[0], rxclk_disable_q};
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (runcmd_strobe_sys) begin
            runcmd_data_q <= runcmd_hold_q;
        end
        if (trig_strobe_sys) begin
            trig_data_q <= trig_hold_q;
        end
    end

    assign fw_mark_o = fw_mark_sys_q;
    assign disable_rxclk_o = rxclk_disable_sys_q[1];

    always_comb begin
        runcmd_o.tdata = runcmd_data_q;
        runcmd_o.tvalid = runcmd_valid_q;
        trig_o.tdata = trig_data_q;
        trig_o.tvalid = trig_valid_q;
    end

    // the master must keep stb up for as long as the ack it asked for is shown
    ack_source_a: assert property (@(posedge wb_clk_i) disable iff (reset_wb)
        wb_rsp_o.ack |-> wb_req_i.cyc && wb_req_i.stb)
        else $error("wishbone ack raised without a request");

    // only a fresh write may replace data that is still waiting
    runcmd_stable_a: assert property (@(posedge sysclk_i) disable iff (reset_i)
        runcmd_o.tvalid && !runcmd_ready_i && !runcmd_strobe_sys |=> $stable(runcmd_o.tdata))
        else $error("run command data changed under back-pressure");

    trig_stable_a: assert property (@(posedge sysclk_i) disable iff (reset_i)
        trig_o.tvalid && !trig_ready_i && !trig_strobe_sys |=> $stable(trig_o.tdata))
        else $error("trigger data changed under back-pressure");

    fw_stable_a: assert property (@(posedge sysclk_i) disable iff (reset_i)
        fw_o.tvalid && !fw_ready_i |=> $stable(fw_o.tdata))
        else $error("firmware byte changed under back-pressure");

endmodule

`default_nettype wire

// ==== hdl/surfturf_regs_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module surfturf_regs_top (
    input  logic                        wb_clk_i,
    input  logic                        sysclk_i,
    input  logic                        reset_i,
    input  surf_regs_pkg::wb_req_t      wb_req_i,
    output surf_regs_pkg::wb_rsp_t      wb_rsp_o,
    output logic                        disable_rxclk_o,
    output rackbus_pkg::fw_stream_t     fw_o,
    input  logic                        fw_ready_i,
    output logic                        fw_mark_o,
    input  logic                        fw_marked_i,
    output rackbus_pkg::runcmd_stream_t runcmd_o,
    input  logic                        runcmd_ready_i,
    output rackbus_pkg::trig_stream_t   trig_o,
    input  logic                        trig_ready_i
);

    // integration boundary of the register block, the core does all the work
    surfturf_register_core surfturf_register_core_inst (
        .wb_clk_i        (wb_clk_i),
        .sysclk_i        (sysclk_i),
        .reset_i         (reset_i),
        .wb_req_i        (wb_req_i),
        .wb_rsp_o        (wb_rsp_o),
        .disable_rxclk_o (disable_rxclk_o),
        .fw_o            (fw_o),
        .fw_ready_i      (fw_ready_i),
        .fw_mark_o       (fw_mark_o),
        .fw_marked_i     (fw_marked_i),
        .runcmd_o        (runcmd_o),
        .runcmd_ready_i  (runcmd_ready_i),
        .trig_o          (trig_o),
        .trig_ready_i    (trig_ready_i)
    );

endmodule

`default_nettype wire

// ==== verification/tb_surfturf_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_surfturf_regs;

    localparam int unsigned sys_period = 4;
    localparam int unsigned wb_period = 10;
    localparam int unsigned reset_cycles = 16;
    // the slowest test needs a few thousand bus cycles, the budget covers all six with margin
    localparam int unsigned wb_cycle_budget = 20000;
    localparam int unsigned ack_limit = 16;
    localparam int unsigned status_polls = 8;

    typedef enum int unsigned {
        runcmd_valid_sel,
        trig_valid_sel,
        fw_mark_sel,
        rxclk_sel
    } sys_signal_e;

    logic sysclk = 1'b0;
    logic wb_clk = 1'b0;
    logic reset = 1'b1;
    surf_regs_pkg::wb_req_t wb_req = '0;
    surf_regs_pkg::wb_rsp_t wb_rsp;
    logic disable_rxclk;
    rackbus_pkg::fw_stream_t fw;
    logic fw_ready = 1'b0;
    logic fw_mark;
    logic fw_marked = 1'b0;
    rackbus_pkg::runcmd_stream_t runcmd;
    logic runcmd_ready = 1'b0;
    rackbus_pkg::trig_stream_t trig;
    logic trig_ready = 1'b0;

    int unsigned error_count = 0;
    logic [31:0] fw_words [$];
    logic [7:0] fw_bytes [$];

    // the two clocks never share an edge pattern, so the crossings are exercised
    always #(sys_period / 2) sysclk = ~sysclk;
    always #(wb_period / 2) wb_clk = ~wb_clk;

    surfturf_regs_top surfturf_regs_top_inst (
        .wb_clk_i        (wb_clk),
        .sysclk_i        (sysclk),
        .reset_i         (reset),
        .wb_req_i        (wb_req),
        .wb_rsp_o        (wb_rsp),
        .disable_rxclk_o (disable_rxclk),
        .fw_o            (fw),
        .fw_ready_i      (fw_ready),
        .fw_mark_o       (fw_mark),
        .fw_marked_i     (fw_marked),
        .runcmd_o        (runcmd),
        .runcmd_ready_i  (runcmd_ready),
        .trig_o          (trig),
        .trig_ready_i    (trig_ready)
    );

    task automatic report_mismatch(input string test, input string what,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("[ERROR] %s: %s expected 0x%08h actual 0x%08h", test, what, expected, actual);
        error_count++;
    endtask

    task automatic note_failure(input string msg);
        $display("[ERROR] %s", msg);
        error_count++;
    endtask

    // one classic cycle, held open across the edge where the acked write commits
    task automatic bus_cycle(input logic we, input logic [3:0] reg_addr, input logic [3:0] sel,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int unsigned waited;
        logic got_ack;
        waited = 0;
        got_ack = 1'b0;
        rdata = '0;
        @(posedge wb_clk);
        #1;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we = we;
        wb_req.adr = {{(surf_regs_pkg::wb_adr_bits - 4){1'b0}}, reg_addr};
        wb_req.sel = sel;
        wb_req.dat = wdata;
        while (!got_ack && waited < ack_limit) begin
            @(posedge wb_clk);
            #1;
            waited++;
            if (wb_rsp.ack) begin
                got_ack = 1'b1;
                rdata = wb_rsp.dat;
                // error and retry are never used by this target
                if (wb_rsp.err !== 1'b0 || wb_rsp.rty !== 1'b0) begin
                    note_failure($sformatf("Wishbone err or rty raised for address 0x%0h",
                                           reg_addr));
                end
            end
        end
        if (!got_ack) begin
            note_failure($sformatf("no Wishbone ack for address 0x%0h", reg_addr));
        end
        @(posedge wb_clk);
        #1;
        wb_req = '0;
    endtask

    task automatic wb_write(input logic [3:0] reg_addr, input logic [3:0] sel,
                            input logic [31:0] wdata);
        logic [31:0] unused;
        bus_cycle(1'b1, reg_addr, sel, wdata, unused);
    endtask

    task automatic wb_read(input logic [3:0] reg_addr, output logic [31:0] rdata);
        bus_cycle(1'b0, reg_addr, 4'b1111, 32'h0, rdata);
    endtask

    task automatic wait_status(input string test, input logic [31:0] mask,
                               input logic [31:0] value, input int unsigned limit);
        logic [31:0] rdata;
        int unsigned polls;
        logic done;
        polls = 0;
        done = 1'b0;
        rdata = '0;
        while (!done && polls < limit) begin
            wb_read(surf_regs_pkg::control_addr, rdata);
            polls++;
            done = ((rdata & mask) == value);
        end
        if (!done) begin
            report_mismatch(test, "status bits", value, rdata & mask);
        end
    endtask

    function automatic logic sys_level(input sys_signal_e id);
        case (id)
            runcmd_valid_sel: return runcmd.tvalid;
            trig_valid_sel:   return trig.tvalid;
            fw_mark_sel:      return fw_mark;
            default:          return disable_rxclk;
        endcase
    endfunction

    task automatic wait_sys_level(input string test, input string what, input sys_signal_e id,
                                  input logic level, input int unsigned limit);
        int unsigned waited;
        waited = 0;
        do begin
            @(posedge sysclk);
            #1;
            waited++;
        end while (sys_level(id) !== level && waited < limit);
        if (sys_level(id) !== level) begin
            note_failure($sformatf("%s: %s did not reach %0b within %0d sysclk cycles",
                                   test, what, level, limit));
        end
    endtask

    // ready is redrawn every cycle, a byte counts when valid and ready meet at the next edge
    task automatic collect_fw_bytes(input int unsigned count, input int unsigned limit);
        int unsigned cycles;
        cycles = 0;
        while (fw_bytes.size() < count && cycles < limit) begin
            @(posedge sysclk);
            #1;
            cycles++;
            fw_ready = (($urandom % 2) == 1);
            if (fw.tvalid && fw_ready) begin
                fw_bytes.push_back(fw.tdata);
            end
        end
        @(posedge sysclk);
        #1;
        fw_ready = 1'b0;
    endtask

    task automatic test_reset();
        surf_regs_pkg::ctrl_word_u expected;
        logic [31:0] rdata;
        expected = '0;
        expected.st.rxclk_disable = 1'b1;
        expected.st.fifo_empty = 1'b1;
        expected.st.runcmd_idle = 1'b1;
        expected.st.trig_idle = 1'b1;
        @(posedge sysclk);
        #1;
        if (runcmd.tvalid !== 1'b0) begin
            report_mismatch("test_reset", "runcmd tvalid", 0, runcmd.tvalid);
        end
        if (trig.tvalid !== 1'b0) report_mismatch("test_reset", "trig tvalid", 0, trig.tvalid);
        if (fw.tvalid !== 1'b0) report_mismatch("test_reset", "fw tvalid", 0, fw.tvalid);
        if (fw_mark !== 1'b0) report_mismatch("test_reset", "fw_mark", 0, fw_mark);
        if (disable_rxclk !== 1'b1) begin
            report_mismatch("test_reset", "disable_rxclk", 1, disable_rxclk);
        end
        wb_read(surf_regs_pkg::control_addr, rdata);
        if (rdata !== expected) report_mismatch("test_reset", "status word", expected, rdata);
    endtask

    task automatic test_runcmd();
        logic [31:0] value;
        logic [rackbus_pkg::runcmd_bits-1:0] expected;
        surf_regs_pkg::ctrl_word_u idle_mask;
        value = 32'h5A5A_00F6;
        expected = value[rackbus_pkg::runcmd_bits-1:0];
        idle_mask = '0;
        idle_mask.st.runcmd_idle = 1'b1;
        wb_write(surf_regs_pkg::runcmd_addr, 4'b0001, value);
        wait_sys_level("test_runcmd", "runcmd tvalid", runcmd_valid_sel, 1'b1, 8);
        if (runcmd.tdata !== expected) begin
            report_mismatch("test_runcmd", "tdata", expected, runcmd.tdata);
        end
        repeat (10) begin
            @(posedge sysclk);
            #1;
            if (runcmd.tvalid !== 1'b1) begin
                report_mismatch("test_runcmd", "held tvalid", 1, runcmd.tvalid);
            end
            if (runcmd.tdata !== expected) begin
                report_mismatch("test_runcmd", "held tdata", expected, runcmd.tdata);
            end
        end
        wait_status("test_runcmd", idle_mask, 32'h0, status_polls);
        @(posedge sysclk);
        #1;
        runcmd_ready = 1'b1;
        @(posedge sysclk);
        #1;
        runcmd_ready = 1'b0;
        if (runcmd.tvalid !== 1'b0) begin
            report_mismatch("test_runcmd", "tvalid after transfer", 0, runcmd.tvalid);
        end
        wait_status("test_runcmd", idle_mask, idle_mask, status_polls);
    endtask

    task automatic test_trig();
        logic [31:0] value;
        logic [rackbus_pkg::trig_bits-1:0] expected;
        surf_regs_pkg::ctrl_word_u idle_mask;
        value = 32'h1234_ABCD;
        expected = value[rackbus_pkg::trig_bits-1:0];
        idle_mask = '0;
        idle_mask.st.trig_idle = 1'b1;
        wb_write(surf_regs_pkg::trig_addr, 4'b0011, value);
        wait_sys_level("test_trig", "trig tvalid", trig_valid_sel, 1'b1, 8);
        if (trig.tdata !== expected) report_mismatch("test_trig", "tdata", expected, trig.tdata);
        trig_ready = 1'b1;
        @(posedge sysclk);
        #1;
        trig_ready = 1'b0;
        if (trig.tvalid !== 1'b0) begin
            report_mismatch("test_trig", "tvalid after transfer", 0, trig.tvalid);
        end
        wait_status("test_trig", idle_mask, idle_mask, status_polls);
        // the trigger word needs both low byte lanes
        wb_write(surf_regs_pkg::trig_addr, 4'b0001, 32'h0000_7FFF);
        repeat (20) begin
            @(posedge sysclk);
            #1;
            if (trig.tvalid !== 1'b0) begin
                report_mismatch("test_trig", "tvalid on partial write", 0, trig.tvalid);
            end
        end
    endtask

    task automatic test_fwupdate();
        logic [31:0] word;
        logic [7:0] expected;
        surf_regs_pkg::ctrl_word_u empty_mask;
        surf_regs_pkg::ctrl_word_u reset_mask;
        surf_regs_pkg::ctrl_word_u ctrl;
        int unsigned transfers;
        int unsigned i;
        fw_words.delete();
        fw_bytes.delete();
        empty_mask = '0;
        empty_mask.st.fifo_empty = 1'b1;
        reset_mask = '0;
        reset_mask.st.fifo_reset = 1'b1;
        for (i = 0; i < 12; i++) begin
            word = $urandom;
            fw_words.push_back(word);
            wb_write(surf_regs_pkg::fwupdate_addr, 4'b1111, word);
        end
        collect_fw_bytes(48, 2000);
        if (fw_bytes.size() != 48) begin
            note_failure($sformatf("test_fwupdate: collected %0d of 48 bytes", fw_bytes.size()));
        end
        for (i = 0; i < fw_bytes.size(); i++) begin
            // byte 0 of each word leaves first
            word = fw_words[i / 4] >> (8 * (i % 4));
            expected = word[7:0];
            if (fw_bytes[i] !== expected) begin
                report_mismatch("test_fwupdate", $sformatf("byte %0d", i), expected, fw_bytes[i]);
            end
        end
        wait_status("test_fwupdate", empty_mask, empty_mask, status_polls);
        repeat (3) wb_write(surf_regs_pkg::fwupdate_addr, 4'b1111, $urandom);
        ctrl = '0;
        ctrl.wr.fifo_reset = 1'b1;
        wb_write(surf_regs_pkg::control_addr, 4'b0001, ctrl);
        wait_status("test_fwupdate", reset_mask, reset_mask, status_polls);
        ctrl.wr.fifo_reset = 1'b0;
        wb_write(surf_regs_pkg::control_addr, 4'b0001, ctrl);
        transfers = 0;
        repeat (40) begin
            @(posedge sysclk);
            #1;
            fw_ready = 1'b1;
            if (fw.tvalid) transfers++;
        end
        fw_ready = 1'b0;
        if (transfers != 0) report_mismatch("test_fwupdate", "bytes after flush", 0, transfers);
        wait_status("test_fwupdate", empty_mask | reset_mask, empty_mask, status_polls);
    endtask

    task automatic test_mark();
        surf_regs_pkg::ctrl_word_u ctrl;
        surf_regs_pkg::ctrl_word_u pending_mask;
        ctrl = '0;
        ctrl.wr.fw_mark_req = 1'b1;
        pending_mask = '0;
        pending_mask.st.fw_mark_pending = 1'b1;
        wb_write(surf_regs_pkg::control_addr, 4'b0010, ctrl);
        wait_sys_level("test_mark", "fw_mark", fw_mark_sel, 1'b1, 8);
        wait_status("test_mark", pending_mask, pending_mask, status_polls);
        @(posedge sysclk);
        #1;
        fw_marked = 1'b1;
        @(posedge sysclk);
        #1;
        if (fw_mark !== 1'b0) report_mismatch("test_mark", "fw_mark after marked", 0, fw_mark);
        @(posedge sysclk);
        #1;
        fw_marked = 1'b0;
        wait_status("test_mark", pending_mask, 32'h0, status_polls);
    endtask

    task automatic test_rxclk();
        surf_regs_pkg::ctrl_word_u ctrl;
        surf_regs_pkg::ctrl_word_u rx_mask;
        ctrl = '0;
        rx_mask = '0;
        rx_mask.st.rxclk_disable = 1'b1;
        wb_write(surf_regs_pkg::control_addr, 4'b1000, ctrl);
        wait_sys_level("test_rxclk", "disable_rxclk", rxclk_sel, 1'b0, 8);
        wait_status("test_rxclk", rx_mask, 32'h0, status_polls);
        ctrl.wr.rxclk_disable = 1'b1;
        wb_write(surf_regs_pkg::control_addr, 4'b1000, ctrl);
        wait_sys_level("test_rxclk", "disable_rxclk", rxclk_sel, 1'b1, 8);
        wait_status("test_rxclk", rx_mask, rx_mask, status_polls);
    endtask

    initial begin
        void'($urandom(68914));
        reset = 1'b1;
        wb_req = '0;
        fw_ready = 1'b0;
        fw_marked = 1'b0;
        runcmd_ready = 1'b0;
        trig_ready = 1'b0;
        repeat (reset_cycles) @(posedge sysclk);
        #1;
        reset = 1'b0;
        // the bus side sees the release through its own two flops
        repeat (4) @(posedge wb_clk);
        #1;
        test_reset();
        test_runcmd();
        test_trig();
        test_fwupdate();
        test_mark();
        test_rxclk();
        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(wb_cycle_budget * wb_period);
        $display("timeout: the tests did not finish within %0d bus cycles", wb_cycle_budget);
        $display("errors: %0d", error_count);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
hdl/rackbus_pkg.sv
hdl/surf_regs_pkg.sv
hdl/flag_sync.sv
hdl/fwupdate_fifo.sv
hdl/surfturf_register_core.sv
hdl/surfturf_regs_top.sv
verification/tb_surfturf_regs.sv

// ==== Bender.yml ====
package:
  name: surfturf_regs

sources:
  - hdl/rackbus_pkg.sv
  - hdl/surf_regs_pkg.sv
  - hdl/flag_sync.sv
  - hdl/fwupdate_fifo.sv
  - hdl/surfturf_register_core.sv
  - hdl/surfturf_regs_top.sv
  - target: test
    files:
      - verification/tb_surfturf_regs.sv
